//--- source/hwag_pkg.sv
// Widths and wheel constants for a 60-2 crank wheel read once per rising tooth edge
// Angles are in 1/64 tooth units, 60 slots per turn including the two missing teeth
package hwag_pkg;

  // Vector widths
  localparam int PERIOD_W = 24;
  localparam int ANGLE_W  = 24;
  localparam int TOOTH_W  = 8;

  // Tooth period in clock cycles
  typedef logic [PERIOD_W-1:0] period_t;

  // Crank angle, 0 to ANGLE_MAX
  typedef logic [ANGLE_W-1:0] angle_t;

  // Tooth index after the gap
  typedef logic [TOOTH_W-1:0] tooth_t;

  // Wheel lock states
  typedef enum logic [1:0] {
    sync_search,
    sync_wait_gap,
    sync_run
  } sync_state_t;

  // Physical teeth on the wheel
  localparam tooth_t TEETH_PER_TURN = 8'd58;

  // Last angle of a turn
  localparam angle_t ANGLE_MAX = 24'd3839;

  // coil23 offset from coil14
  localparam angle_t HALF_TURN = 24'd1920;

endpackage

//--- source/tooth_capture.sv
// cap_in is asynchronous; pulses shorter than FILT_LEN clocks never reach cap_out
// Only rising edges produce tooth_edge, one cycle after cap_out rises
`timescale 1ns/10ps

module tooth_capture #(
  parameter int FILT_LEN = 7
) (
  input  logic clk,
  input  logic rst,
  input  logic cap_in,
  output logic cap_out,
  output logic tooth_edge
);

  localparam int CNT_W = (FILT_LEN > 1) ? $clog2(FILT_LEN) : 1;

  logic             sync_q1;
  logic             sync_q2;
  logic [CNT_W-1:0] diff_cnt;
  logic             cap_prev;

  // Two-flop synchroniser
  always_ff @(posedge clk) begin
    if (rst) begin
      sync_q1 <= 1'b0;
      sync_q2 <= 1'b0;
    end else begin
      sync_q1 <= cap_in;
      sync_q2 <= sync_q1;
    end
  end

  // Counts samples that differ from cap_out
  // any sample equal to cap_out restarts the window
  always_ff @(posedge clk) begin
    if (rst) begin
      diff_cnt <= '0;
      cap_out  <= 1'b0;
    end else if (sync_q2 == cap_out) begin
      diff_cnt <= '0;
    end else if (diff_cnt == CNT_W'(FILT_LEN - 1)) begin
      diff_cnt <= '0;
      cap_out  <= sync_q2;
    end else begin
      diff_cnt <= diff_cnt + 1'b1;
    end
  end

  // Rising edge of the filtered level
  always_ff @(posedge clk) begin
    if (rst) begin
      cap_prev   <= 1'b0;
      tooth_edge <= 1'b0;
    end else begin
      cap_prev   <= cap_out;
      tooth_edge <= cap_out & ~cap_prev;
    end
  end

endmodule

//--- source/gap_sync.sv
// The gap is a period at least twice the one before it, with the three held periods in range
// A wheel slower than PERIOD_MAX cycles per tooth counts as stopped and drops the lock
`timescale 1ns/10ps

module gap_sync #(
  parameter int PERIOD_MIN = 512,
  parameter int PERIOD_MAX = 5592405
) (
  input  logic              clk,
  input  logic              rst,
  input  logic              tooth_edge,
  output logic              synced,
  output logic              at_gap,
  output hwag_pkg::tooth_t  tooth_index,
  output hwag_pkg::period_t last_period
);

  import hwag_pkg::*;

  localparam period_t P_MIN      = period_t'(PERIOD_MIN);
  localparam period_t P_MAX      = period_t'(PERIOD_MAX);
  localparam tooth_t  LAST_TOOTH = TEETH_PER_TURN - 1'b1;

  period_t     pcnt;
  period_t     new_period;
  period_t     cap1;
  period_t     cap2;
  logic        timeout;
  logic        hist_ok;
  logic        gap_now;
  sync_state_t state;

  function automatic logic in_range(period_t p);
    return (p >= P_MIN) && (p <= P_MAX);
  endfunction

  assign new_period = pcnt + 1'b1;
  assign timeout    = (pcnt == P_MAX);
  assign hist_ok    = in_range(last_period) && in_range(cap1) && in_range(cap2);

  // Newest period against the held one, checked in the edge cycle itself
  assign gap_now = tooth_edge && hist_ok && ({1'b0, new_period} >= {last_period, 1'b0});

  // Saturating period counter and three-deep history
  always_ff @(posedge clk) begin
    if (rst) begin
      pcnt        <= '0;
      last_period <= '0;
      cap1        <= '0;
      cap2        <= '0;
    end else if (tooth_edge) begin
      pcnt        <= '0;
      last_period <= new_period;
      cap1        <= last_period;
      cap2        <= cap1;
    end else if (timeout) begin
      last_period <= '0;
      cap1        <= '0;
      cap2        <= '0;
    end else begin
      pcnt <= pcnt + 1'b1;
    end
  end

  // Lock FSM and tooth counter
  always_ff @(posedge clk) begin
    if (rst) begin
      state       <= sync_search;
      tooth_index <= '0;
    end else if (timeout) begin
      state       <= sync_search;
      tooth_index <= '0;
    end else if (tooth_edge) begin
      case (state)
        sync_search: begin
          if (gap_now) begin
            state       <= sync_run;
            tooth_index <= '0;
          end else if (hist_ok) begin
            state <= sync_wait_gap;
          end
        end
        sync_wait_gap: begin
          if (gap_now) begin
            state       <= sync_run;
            tooth_index <= '0;
          end else if (!hist_ok) begin
            state <= sync_search;
          end
        end
        sync_run: begin
          // Gap must close the turn, and nothing may follow the last tooth but the gap
          if (gap_now && tooth_index == LAST_TOOTH) begin
            tooth_index <= '0;
          end else if (gap_now || tooth_index == LAST_TOOTH) begin
            state       <= sync_search;
            tooth_index <= '0;
          end else begin
            tooth_index <= tooth_index + 1'b1;
          end
        end
        default: begin
          state       <= sync_search;
          tooth_index <= '0;
        end
      endcase
    end
  end

  assign synced = (state == sync_run);

  // First tooth after the gap
  assign at_gap = synced && (tooth_index == '0);

endmodule

//--- source/angle_counter.sv
// One step every last_period >> ANGLE_SHIFT cycles; a tooth never steps past its own slots
// The last tooth before the gap spans three slots, so the turn still ends at ANGLE_MAX
`timescale 1ns/10ps

module angle_counter #(
  parameter int ANGLE_SHIFT = 6
) (
  input  logic              clk,
  input  logic              rst,
  input  logic              tooth_edge,
  input  logic              synced,
  input  hwag_pkg::tooth_t  tooth_index,
  input  hwag_pkg::period_t last_period,
  output hwag_pkg::angle_t  crank_angle,
  output hwag_pkg::angle_t  cyl14_angle,
  output hwag_pkg::angle_t  cyl23_angle
);

  import hwag_pkg::*;

  localparam int                STEP_W      = ANGLE_SHIFT + 2;
  localparam logic [STEP_W-1:0] STEPS_TOOTH = STEP_W'((1 << ANGLE_SHIFT) - 1);
  localparam logic [STEP_W-1:0] STEPS_GAP   = STEP_W'(3 * (1 << ANGLE_SHIFT) - 1);
  localparam tooth_t            LAST_TOOTH  = TEETH_PER_TURN - 1'b1;

  period_t           step_len;
  period_t           step_cnt;
  logic [STEP_W-1:0] steps;
  logic [STEP_W-1:0] steps_max;
  logic              tooth_start;
  logic              step_due;
  angle_t            cyl23_sum;

  assign step_len  = last_period >> ANGLE_SHIFT;
  assign steps_max = (tooth_index == LAST_TOOTH) ? STEPS_GAP : STEPS_TOOTH;
  assign step_due  = (step_cnt + 1'b1 >= step_len) && (steps < steps_max);

  // tooth_index and last_period settle one cycle after the edge
  always_ff @(posedge clk) begin
    if (rst) begin
      tooth_start <= 1'b0;
    end else begin
      tooth_start <= tooth_edge;
    end
  end

  // Step divider and crank angle
  always_ff @(posedge clk) begin
    if (rst || !synced) begin
      step_cnt    <= '0;
      steps       <= '0;
      crank_angle <= '0;
    end else if (tooth_start) begin
      step_cnt    <= '0;
      steps       <= '0;
      crank_angle <= angle_t'(tooth_index) << ANGLE_SHIFT;
    end else if (step_due) begin
      step_cnt    <= '0;
      steps       <= steps + 1'b1;
      crank_angle <= (crank_angle == ANGLE_MAX) ? '0 : crank_angle + 1'b1;
    end else if (steps < steps_max) begin
      step_cnt <= step_cnt + 1'b1;
    end
  end

  // Cylinder angles, second pair half a turn on
  assign cyl23_sum   = crank_angle + HALF_TURN;
  assign cyl14_angle = crank_angle;

  always_comb begin
    if (!synced) begin
      cyl23_angle = '0;
    end else if (cyl23_sum > ANGLE_MAX) begin
      cyl23_angle = cyl23_sum - (ANGLE_MAX + 1'b1);
    end else begin
      cyl23_angle = cyl23_sum;
    end
  end

endmodule

//--- source/coil_driver.sv
// Ignition and dwell are crank angles in 1/64 tooth units, shared by both coils
// A new set point is taken at a tooth edge only while the coil has not yet reached it
`timescale 1ns/10ps

module coil_driver (
  input  logic             clk,
  input  logic             rst,
  input  logic             tooth_edge,
  input  logic             synced,
  input  hwag_pkg::angle_t cyl14_angle,
  input  hwag_pkg::angle_t cyl23_angle,
  input  hwag_pkg::angle_t ignition_angle,
  input  hwag_pkg::angle_t dwell_angle,
  output logic             coil14,
  output logic             coil23
);

  import hwag_pkg::*;

  angle_t     set_point;
  angle_t     cyl_angle [2];
  angle_t     shadow    [2];
  logic [1:0] set_hit;
  logic [1:0] clr_hit;
  logic [1:0] coil_q;

  // Dwell start, wrapped back into the turn
  always_comb begin
    if (ignition_angle >= dwell_angle) begin
      set_point = ignition_angle - dwell_angle;
    end else begin
      set_point = ignition_angle + (ANGLE_MAX + 1'b1) - dwell_angle;
    end
  end

  assign cyl_angle[0] = cyl14_angle;
  assign cyl_angle[1] = cyl23_angle;

  always_comb begin
    for (int i = 0; i < 2; i++) begin
      set_hit[i] = (cyl_angle[i] == shadow[i]);
      clr_hit[i] = (cyl_angle[i] == ignition_angle);
    end
  end

  // Shadow set points, one per coil
  always_ff @(posedge clk) begin
    for (int i = 0; i < 2; i++) begin
      if (rst) begin
        shadow[i] <= '0;
      end else if (tooth_edge && (cyl_angle[i] < set_point)) begin
        shadow[i] <= set_point;
      end
    end
  end

  // Ignition point wins over dwell start
  always_ff @(posedge clk) begin
    if (rst || !synced) begin
      coil_q <= '0;
    end else begin
      for (int i = 0; i < 2; i++) begin
        if (clr_hit[i]) begin
          coil_q[i] <= 1'b0;
        end else if (set_hit[i]) begin
          coil_q[i] <= 1'b1;
        end
      end
    end
  end

  assign coil14 = coil_q[0] & synced;
  assign coil23 = coil_q[1] & synced;

endmodule

//--- source/hwag.sv
// Two-coil wasted-spark angle generator for a 60-2 wheel; coil23 runs half a turn after coil14
// ignition_angle and dwell_angle are static levels in 1/64 tooth units, no bus interface
`timescale 1ns/10ps

module hwag #(
  parameter int ANGLE_SHIFT = 6,
  parameter int FILT_LEN    = 7,
  parameter int PERIOD_MIN  = 512,
  parameter int PERIOD_MAX  = 5592405
) (
  input  logic             clk,
  input  logic             rst,
  input  logic             cap_in,
  input  hwag_pkg::angle_t ignition_angle,
  input  hwag_pkg::angle_t dwell_angle,
  output logic             cap_out,
  output logic             synced,
  output logic             coil14,
  output logic             coil23
);

  import hwag_pkg::*;

  logic    tooth_edge;
  tooth_t  tooth_index;
  period_t last_period;
  angle_t  cyl14_angle;
  angle_t  cyl23_angle;

  tooth_capture #(
    .FILT_LEN (FILT_LEN)
  ) u_tooth_capture (
    .clk        (clk),
    .rst        (rst),
    .cap_in     (cap_in),
    .cap_out    (cap_out),
    .tooth_edge (tooth_edge)
  );

  gap_sync #(
    .PERIOD_MIN (PERIOD_MIN),
    .PERIOD_MAX (PERIOD_MAX)
  ) u_gap_sync (
    .clk         (clk),
    .rst         (rst),
    .tooth_edge  (tooth_edge),
    .synced      (synced),
    .at_gap      (),
    .tooth_index (tooth_index),
    .last_period (last_period)
  );

  angle_counter #(
    .ANGLE_SHIFT (ANGLE_SHIFT)
  ) u_angle_counter (
    .clk         (clk),
    .rst         (rst),
    .tooth_edge  (tooth_edge),
    .synced      (synced),
    .tooth_index (tooth_index),
    .last_period (last_period),
    .crank_angle (),
    .cyl14_angle (cyl14_angle),
    .cyl23_angle (cyl23_angle)
  );

  coil_driver u_coil_driver (
    .clk            (clk),
    .rst            (rst),
    .tooth_edge     (tooth_edge),
    .synced         (synced),
    .cyl14_angle    (cyl14_angle),
    .cyl23_angle    (cyl23_angle),
    .ignition_angle (ignition_angle),
    .dwell_angle    (dwell_angle),
    .coil14         (coil14),
    .coil23         (coil23)
  );

endmodule

//--- test/hwag_sva.sv
// Bound into coil_driver; ignition and dwell are taken as static levels
`timescale 1ns/10ps

module hwag_sva (
  input logic             clk,
  input logic             rst,
  input logic             synced,
  input logic             coil14,
  input logic             coil23,
  input hwag_pkg::angle_t cyl14_angle,
  input hwag_pkg::angle_t cyl23_angle,
  input hwag_pkg::angle_t ignition_angle,
  input hwag_pkg::angle_t dwell_angle
);

  import hwag_pkg::*;

  int unsigned fail_count = 0;

  // Dwell window, possibly wrapping past the end of the turn
  function automatic logic in_window(angle_t a, angle_t ign, angle_t dwell);
    angle_t start;
    if (ign >= dwell) begin
      start = ign - dwell;
    end else begin
      start = ign + (ANGLE_MAX + 1'b1) - dwell;
    end
    if (start <= ign) begin
      return (a >= start) && (a < ign);
    end else begin
      return (a >= start) || (a < ign);
    end
  endfunction

  // Coils stay low through the cycle in which the lock comes back
  no_coil_unsynced: assert property (@(posedge clk) disable iff (rst)
    !synced |=> (!coil14 && !coil23))
    else begin
      $error("coil active right after the wheel was unlocked");
      fail_count++;
    end

  // Set is registered, so the angle one cycle back is the one that matched
  coil14_rise_window: assert property (@(posedge clk) disable iff (rst)
    $rose(coil14) |-> in_window($past(cyl14_angle), ignition_angle, dwell_angle))
    else begin
      $error("coil14 rose outside its dwell window");
      fail_count++;
    end

  coil23_rise_window: assert property (@(posedge clk) disable iff (rst)
    $rose(coil23) |-> in_window($past(cyl23_angle), ignition_angle, dwell_angle))
    else begin
      $error("coil23 rose outside its dwell window");
      fail_count++;
    end

endmodule

bind coil_driver hwag_sva u_hwag_sva (
  .clk            (clk),
  .rst            (rst),
  .synced         (synced),
  .coil14         (coil14),
  .coil23         (coil23),
  .cyl14_angle    (cyl14_angle),
  .cyl23_angle    (cyl23_angle),
  .ignition_angle (ignition_angle),
  .dwell_angle    (dwell_angle)
);

//--- test/hwag_tb.sv
// Drives a 60-2 wheel at 1024 clocks per tooth with fixed ignition 1000 and dwell 320
// Coils are sampled at mid-tooth, well clear of the set and clear angles
`timescale 1ns/10ps

module hwag_tb;

  import hwag_pkg::*;

  localparam int ANGLE_SHIFT = 6;
  localparam int FILT_LEN    = 7;
  localparam int PERIOD_MIN  = 512;
  localparam int PERIOD_MAX  = 5592405;
  localparam int P           = 1024;
  localparam int UNITS       = 1 << ANGLE_SHIFT;
  localparam int TURN        = int'(ANGLE_MAX) + 1;
  localparam int IGN_ANGLE   = 1000;
  localparam int DWELL_ANGLE = 320;
  localparam int REG_TEETH   = 10;
  localparam int STOP_TOOTH  = 13;

  logic   clk = 1'b0;
  logic   rst;
  logic   cap_in;
  angle_t ignition_angle;
  angle_t dwell_angle;
  logic   cap_out;
  logic   synced;
  logic   coil14;
  logic   coil23;

  // Compare process controls, written by the stimulus side
  logic        mid_strobe;
  logic        low_strobe;
  int          mid_tooth;
  logic        watch_sync;
  logic        sync_level;
  logic        coil_check;
  int          err_count = 0;
  int unsigned lcg_state = 1;

  hwag #(
    .ANGLE_SHIFT (ANGLE_SHIFT),
    .FILT_LEN    (FILT_LEN),
    .PERIOD_MIN  (PERIOD_MIN),
    .PERIOD_MAX  (PERIOD_MAX)
  ) u_hwag (
    .clk            (clk),
    .rst            (rst),
    .cap_in         (cap_in),
    .ignition_angle (ignition_angle),
    .dwell_angle    (dwell_angle),
    .cap_out        (cap_out),
    .synced         (synced),
    .coil14         (coil14),
    .coil23         (coil23)
  );

  always #5 clk = ~clk;

  function automatic int unsigned lcg_next();
    lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
    return lcg_state >> 16;
  endfunction

  // Coil is on while its angle sits in [ignition - dwell, ignition)
  function automatic logic expected_coil(input int tooth, input bit second);
    int angle;
    int start;
    start = IGN_ANGLE - DWELL_ANGLE;
    if (start < 0) begin
      start = start + TURN;
    end
    angle = tooth * UNITS + UNITS / 2;
    if (second) begin
      angle = (angle + int'(HALF_TURN)) % TURN;
    end
    if (start <= IGN_ANGLE) begin
      return (angle >= start) && (angle < IGN_ANGLE);
    end else begin
      return (angle >= start) || (angle < IGN_ANGLE);
    end
  endfunction

  task automatic stop_with_fail();
    $display("** FAIL **");
    $fatal(1, "Simulation stopped on error");
  endtask

  task automatic check_value(input string name, input logic [31:0] got,
                             input logic [31:0] exp);
    if (got !== exp) begin
      err_count++;
      $display("FAILED at %0t: %s = %0d, expected %0d", $time, name, got, exp);
      stop_with_fail();
    end
  endtask

  task automatic wait_for_sync(input logic level, input int limit, input string what);
    int n;
    n = 0;
    while (synced !== level && n < limit) begin
      @(negedge clk);
      n++;
    end
    if (synced !== level) begin
      $display("Timeout at %0t: synced did not go to %0d within %0d cycles (%s)",
               $time, level, limit, what);
      stop_with_fail();
    end
  endtask

  // One tooth: high half, low half plus extra, optional short glitch in each half
  task automatic drive_tooth(input int k, input int extra_low, input bit noisy);
    int hi_pos;
    int hi_len;
    int lo_pos;
    int lo_len;
    hi_pos = 100 + int'(lcg_next() % 300);
    hi_len = noisy ? 1 + int'(lcg_next() % (FILT_LEN - 2)) : 0;
    lo_pos = 100 + int'(lcg_next() % 300);
    lo_len = noisy ? 1 + int'(lcg_next() % (FILT_LEN - 2)) : 0;
    for (int i = 0; i < P / 2; i++) begin
      @(posedge clk);
      cap_in     <= !((i >= hi_pos) && (i < hi_pos + hi_len));
      mid_strobe <= (i == P / 2 - 1);
      low_strobe <= 1'b0;
      mid_tooth  <= k;
    end
    for (int i = 0; i < P / 2 + extra_low; i++) begin
      @(posedge clk);
      cap_in     <= (i >= lo_pos) && (i < lo_pos + lo_len);
      mid_strobe <= 1'b0;
      low_strobe <= (i == P / 4);
    end
  endtask

  // Tooth 57 carries the two missing teeth
  task automatic drive_turn(input bit noisy);
    for (int k = 0; k < int'(TEETH_PER_TURN); k++) begin
      drive_tooth(k, (k == int'(TEETH_PER_TURN) - 1) ? 2 * P : 0, noisy);
    end
  endtask

  // Next tooth is the gap edge; lock must come before the tooth after it
  task automatic run_synced_turns(input int turns, input bit noisy);
    watch_sync <= 1'b0;
    fork
      begin
        repeat (turns) drive_turn(noisy);
      end
      begin
        wait_for_sync(1'b1, P, "lock after the gap");
        sync_level <= 1'b1;
        watch_sync <= 1'b1;
        coil_check <= 1'b1;
      end
    join
    watch_sync <= 1'b0;
    coil_check <= 1'b0;
  endtask

  always @(negedge clk) begin
    // Failures counted by the bound checker
    if (u_hwag.u_coil_driver.u_hwag_sva.fail_count != 0) begin
      $display("Bound assertion failed at %0t, see the error above", $time);
      stop_with_fail();
    end
    if (!rst) begin
      if (watch_sync) begin
        check_value("synced", synced, sync_level);
      end
      check_value("coil14 & coil23", coil14 & coil23, 0);
      if (mid_strobe) begin
        check_value("cap_out", cap_out, 1);
      end
      if (low_strobe) begin
        check_value("cap_out", cap_out, 0);
      end
      if (coil_check && mid_strobe) begin
        check_value("coil14", coil14, expected_coil(mid_tooth, 1'b0));
        check_value("coil23", coil23, expected_coil(mid_tooth, 1'b1));
      end
    end
  end

  initial begin
    rst            <= 1'b1;
    cap_in         <= 1'b0;
    ignition_angle <= angle_t'(IGN_ANGLE);
    dwell_angle    <= angle_t'(DWELL_ANGLE);
    mid_strobe     <= 1'b0;
    low_strobe     <= 1'b0;
    mid_tooth      <= 0;
    watch_sync     <= 1'b0;
    sync_level     <= 1'b0;
    coil_check     <= 1'b0;
    repeat (4) @(posedge clk);
    rst <= 1'b0;
    @(negedge clk);
    check_value("synced", synced, 0);
    check_value("coil14", coil14, 0);
    check_value("coil23", coil23, 0);

    // Regular teeth only, then one full turn before any gap edge
    sync_level <= 1'b0;
    watch_sync <= 1'b1;
    repeat (REG_TEETH) drive_tooth(0, 0, 1'b0);
    drive_turn(1'b0);
    run_synced_turns(5, 1'b0);

    // Stopped wheel, halted while coil14 dwells
    for (int k = 0; k < STOP_TOOTH; k++) begin
      drive_tooth(k, 0, 1'b0);
    end
    @(negedge clk);
    check_value("coil14", coil14, expected_coil(STOP_TOOTH - 1, 1'b0));
    wait_for_sync(1'b0, PERIOD_MAX + 2, "stopped wheel");
    check_value("coil14", coil14, 0);
    check_value("coil23", coil23, 0);

    // Same again with glitches on cap_in
    sync_level <= 1'b0;
    watch_sync <= 1'b1;
    drive_turn(1'b1);
    run_synced_turns(3, 1'b1);

    if (err_count == 0) begin
      $display("** PASS **");
      $finish;
    end else begin
      stop_with_fail();
    end
  end

endmodule

//--- list.f
source/hwag_pkg.sv
source/tooth_capture.sv
source/gap_sync.sv
source/angle_counter.sv
source/coil_driver.sv
source/hwag.sv
test/hwag_sva.sv
test/hwag_tb.sv
